// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := vtx_bram_core_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := No errors

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard logic/*.svh dv/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/vtx_bram_model.svh ====
`ifndef VTX_BRAM_MODEL_SVH
`define VTX_BRAM_MODEL_SVH

// mirror of the depth bank
depth_t model_mem [0:(1 << `BANK_AWIDTH)-1];

// expected outputs, ring indexed by rising edge number
logic exp_src_valid [0:7];
depth_t exp_src_value [0:7];
logic exp_act_valid [0:7];
v_id_t exp_act_id [0:7];
logic exp_act_updated [0:7];
logic exp_act_pf [0:7];
logic exp_iter_end [0:7];

// bank writes due on a given edge
logic due_wr_en [0:7];
bank_addr_t due_wr_addr [0:7];
depth_t due_wr_data [0:7];

// request sampled on the last edge, it looks up the bank on the next
logic acc_valid;
logic acc_push;
v_id_t acc_id;
depth_t acc_depth;
logic acc_pf;

// reads or pushes accepted on the last three edges
logic [2:0] in_flight;
logic seed_due;
bank_addr_t model_root;
integer edge_num;

function automatic logic [2:0] slot_of(input integer e);
    slot_of = e[2:0];
endfunction

// interleave bits dropped
function automatic bank_addr_t bank_of(input v_id_t id);
    bank_of = id[`V_ID_WIDTH-1:`CORE_NUM_WIDTH];
endfunction

task automatic clear_slot(input logic [2:0] s);
    exp_src_valid[s] = 1'b0;
    exp_act_valid[s] = 1'b0;
    exp_iter_end[s] = 1'b0;
    due_wr_en[s] = 1'b0;
endtask

task automatic expect_active(input logic [2:0] s, input v_id_t id, input logic upd,
                             input logic pf);
    exp_act_valid[s] = 1'b1;
    exp_act_id[s] = id;
    exp_act_updated[s] = upd;
    exp_act_pf[s] = pf;
endtask

task automatic reset_mirror(input v_id_t root);
    integer i;
    for (i = 0; i < (1 << `BANK_AWIDTH); i = i + 1) begin
        model_mem[i] = `INVALID_BFS_VALUE;
    end
    for (i = 0; i < 8; i = i + 1) begin
        clear_slot(i[2:0]);
    end
    acc_valid = 1'b0;
    in_flight = 3'b000;
    seed_due = 1'b1;
    model_root = bank_of(root);
    edge_num = 0;
endtask

// one rising edge, sees the inputs just driven for it
task automatic advance_edge();
    logic [2:0] now;
    logic [2:0] nxt;
    logic [2:0] res;
    logic win;
    depth_t stored;
    now = slot_of(edge_num);
    nxt = slot_of(edge_num + 1);
    res = slot_of(edge_num + 3);
    // last edge's lookup, before this edge's write lands
    if (acc_valid) begin
        if (!acc_push && acc_id == {`V_ID_WIDTH{1'b1}}) begin
            stored = `INVALID_PULL_VALUE;
        end else begin
            stored = model_mem[bank_of(acc_id)];
        end
        win = (stored == `INVALID_BFS_VALUE) || (stored > acc_depth);
        if (acc_push) begin
            due_wr_en[res] = win;
            due_wr_addr[res] = bank_of(acc_id);
            due_wr_data[res] = acc_depth;
            expect_active(res, acc_id, win, acc_pf);
        end else begin
            exp_src_valid[res] = 1'b1;
            exp_src_value[res] = stored;
        end
    end
    // root seed on the first edge out of reset
    if (seed_due) begin
        model_mem[model_root] = '0;
    end else if (due_wr_en[now]) begin
        model_mem[due_wr_addr[now]] = due_wr_data[now];
    end
    seed_due = 1'b0;
    clear_slot(now);
    // a read masks a push
    acc_valid = rd_valid_src || (wr_valid_dst && wr_push_flag_dst);
    acc_push = !rd_valid_src;
    acc_id = rd_valid_src ? rd_addr_src : wr_addr_dst;
    acc_depth = wr_v_value_dst;
    acc_pf = wr_pull_first_flag_dst;
    // pull takes the write port and the report on the next edge
    if (wr_valid_dst && !wr_push_flag_dst) begin
        win = (wr_v_value_dst != `INVALID_BFS_VALUE) &&
              (wr_v_value_dst <= front_iteration_id);
        due_wr_en[nxt] = win;
        due_wr_addr[nxt] = bank_of(wr_addr_dst);
        due_wr_data[nxt] = wr_v_value_dst + 1'b1;
        expect_active(nxt, wr_addr_dst, win, wr_pull_first_flag_dst);
    end
    exp_iter_end[nxt] = front_iteration_end && front_iteration_end_valid &&
                        (in_flight == 3'b000);
    in_flight = {in_flight[1:0], acc_valid};
    edge_num = edge_num + 1;
endtask

function automatic logic work_pending();
    integer k;
    work_pending = acc_valid || (in_flight != 3'b000);
    for (k = 0; k < 8; k = k + 1) begin
        work_pending = work_pending || exp_src_valid[k] || exp_act_valid[k] ||
                       exp_iter_end[k] || due_wr_en[k];
    end
endfunction

`endif

// ==== dv/vtx_bram_core_tb.sv ====
`default_nettype none

`include "vtx_macros.svh"

module vtx_bram_core_tb
    import vtx_pkg::*;
();

    logic clk;
    logic rst;
    logic rd_valid_src;
    v_id_t rd_addr_src;
    logic wr_valid_dst;
    logic wr_push_flag_dst;
    v_id_t wr_addr_dst;
    depth_t wr_v_value_dst;
    logic wr_pull_first_flag_dst;
    logic front_iteration_end;
    logic front_iteration_end_valid;
    iter_id_t front_iteration_id;
    v_id_t front_root_id;
    logic src_recv_update_v_valid;
    depth_t src_recv_update_v_value;
    logic backend_active_v_valid;
    v_id_t backend_active_v_id;
    logic backend_active_v_updated;
    logic backend_active_v_pull_first_flag;
    logic iteration_end;
    logic iteration_end_valid;

    integer seed;
    integer err_count;
    integer n;
    logic [31:0] r;
    iter_id_t cur_iter;

    `include "vtx_bram_model.svh"

    vtx_bram_core UUT (.*);

    always #10 clk = ~clk;

    task automatic stop_on_error(input string what);
        err_count = err_count + 1;
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_depth(input string name, input depth_t got, input depth_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s got %0h expected %0h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_id(input string name, input v_id_t got, input v_id_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s got %0h expected %0h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s got %0b expected %0b",
                                    $time, name, got, exp));
        end
    endtask

    // outputs registered on the last edge, checked between edges
    task automatic verify_outputs();
        logic [2:0] s;
        s = slot_of(edge_num);
        check_flag("src_recv_update_v_valid", src_recv_update_v_valid, exp_src_valid[s]);
        if (exp_src_valid[s]) begin
            check_depth("src_recv_update_v_value", src_recv_update_v_value, exp_src_value[s]);
        end
        check_flag("backend_active_v_valid", backend_active_v_valid, exp_act_valid[s]);
        if (exp_act_valid[s]) begin
            check_id("backend_active_v_id", backend_active_v_id, exp_act_id[s]);
            check_flag("backend_active_v_updated", backend_active_v_updated,
                       exp_act_updated[s]);
            check_flag("backend_active_v_pull_first_flag", backend_active_v_pull_first_flag,
                       exp_act_pf[s]);
        end
        check_flag("iteration_end", iteration_end, exp_iter_end[s]);
        check_flag("iteration_end_valid", iteration_end_valid, exp_iter_end[s]);
    endtask

    task automatic run_cycle(input logic rv, input v_id_t ra, input logic wv, input logic wp,
                             input v_id_t wa, input depth_t wd, input logic wpf,
                             input logic fe, input logic fev);
        @(negedge clk);
        verify_outputs();
        rst = 1'b0;
        rd_valid_src = rv;
        rd_addr_src = ra;
        wr_valid_dst = wv;
        wr_push_flag_dst = wp;
        wr_addr_dst = wa;
        wr_v_value_dst = wd;
        wr_pull_first_flag_dst = wpf;
        front_iteration_end = fe;
        front_iteration_end_valid = fev;
        front_iteration_id = cur_iter;
        advance_edge();
    endtask

    task automatic idle(input integer cycles);
        integer k;
        for (k = 0; k < cycles; k = k + 1) begin
            run_cycle(1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic read_vertex(input v_id_t id);
        run_cycle(1'b1, id, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic push_depth(input v_id_t id, input depth_t d, input logic pf);
        run_cycle(1'b0, '0, 1'b1, 1'b1, id, d, pf, 1'b0, 1'b0);
    endtask

    task automatic pull_depth(input v_id_t id, input depth_t d, input logic pf);
        run_cycle(1'b0, '0, 1'b1, 1'b0, id, d, pf, 1'b0, 1'b0);
    endtask

    // three bank words, each reached by four ids, plus the null id
    function automatic v_id_t pick_id(input logic [3:0] k);
        if (k == 4'hf) begin
            pick_id = {`V_ID_WIDTH{1'b1}};
        end else begin
            pick_id = 12'h010 + {8'h00, k % 4'd12};
        end
    endfunction

    initial begin
        seed = 32'h48e;
        err_count = 0;
        cur_iter = '0;
        clk = 1'b0;
        rst = 1'b1;
        rd_valid_src = 1'b0;
        rd_addr_src = '0;
        wr_valid_dst = 1'b0;
        wr_push_flag_dst = 1'b0;
        wr_addr_dst = '0;
        wr_v_value_dst = '0;
        wr_pull_first_flag_dst = 1'b0;
        front_iteration_end = 1'b0;
        front_iteration_end_valid = 1'b0;
        front_iteration_id = '0;
        front_root_id = 12'h010;
        repeat (10) @(posedge clk);
        reset_mirror(front_root_id);
        // root, untouched and null reads
        idle(2);
        read_vertex(12'h010);
        read_vertex(12'h024);
        read_vertex({`V_ID_WIDTH{1'b1}});
        idle(4);
        // unvisited, deeper, then shallower push on one word
        push_depth(12'h024, 8'd5, 1'b1);
        idle(4);
        push_depth(12'h025, 8'd7, 1'b0);
        idle(4);
        push_depth(12'h026, 8'd2, 1'b0);
        idle(4);
        read_vertex(12'h027);
        // pulls against the iteration limit
        cur_iter = 8'd3;
        pull_depth(12'h030, 8'd3, 1'b1);
        pull_depth(12'h034, 8'd4, 1'b0);
        pull_depth(12'h038, `INVALID_BFS_VALUE, 1'b1);
        idle(1);
        read_vertex(12'h030);
        // read and push together, then a push result landing in a pull cycle
        run_cycle(1'b1, 12'h040, 1'b1, 1'b1, 12'h044, 8'd1, 1'b0, 1'b0, 1'b0);
        push_depth(12'h048, 8'd1, 1'b0);
        idle(2);
        pull_depth(12'h04c, 8'd0, 1'b1);
        idle(4);
        read_vertex(12'h044);
        read_vertex(12'h048);
        idle(4);
        // iteration end when quiet, then with a read in flight
        run_cycle(1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b0, 1'b1, 1'b1);
        read_vertex(12'h010);
        run_cycle(1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b0, 1'b1, 1'b1);
        idle(4);
        // random traffic, words collide through the small pool
        for (n = 0; n < 4000; n = n + 1) begin
            r = $random(seed);
            if (r[7:4] == 4'h0) begin
                cur_iter = iter_id_t'(r[10:8]);
            end
            run_cycle(r[0] & r[3], pick_id(r[15:12]), r[1], r[2], pick_id(r[19:16]),
                      (r[23:20] == 4'hf) ? `INVALID_BFS_VALUE : depth_t'(r[23:20]),
                      r[24], r[25] & r[26], r[27]);
        end
        // let every outstanding result come out
        n = 0;
        while (work_pending()) begin
            if (n == 16) begin
                stop_on_error("timeout: request pipeline did not drain");
            end
            idle(1);
            n = n + 1;
        end
        idle(2);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/vtx_bram_core.sv ====
`default_nettype none

module vtx_bram_core
    import vtx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     rd_valid_src,
    input  v_id_t    rd_addr_src,
    input  logic     wr_valid_dst,
    input  logic     wr_push_flag_dst,
    input  v_id_t    wr_addr_dst,
    input  depth_t   wr_v_value_dst,
    input  logic     wr_pull_first_flag_dst,
    input  logic     front_iteration_end,
    input  logic     front_iteration_end_valid,
    input  iter_id_t front_iteration_id,
    input  v_id_t    front_root_id,
    output logic     src_recv_update_v_valid,
    output depth_t   src_recv_update_v_value,
    output logic     backend_active_v_valid,
    output v_id_t    backend_active_v_id,
    output logic     backend_active_v_updated,
    output logic     backend_active_v_pull_first_flag,
    output logic     iteration_end,
    output logic     iteration_end_valid
);

    // issuer to bank
    logic rd_req;
    bank_addr_t rd_bank_addr;
    logic rd_null;

    // issuer to fifo
    logic fifo_push;
    v_id_t fifo_id;
    depth_t fifo_depth;
    logic fifo_push_flag;
    logic fifo_pull_first;

    // pull path, issuer to resolver
    logic pull_wr;
    bank_addr_t pull_wr_addr;
    depth_t pull_wr_data;
    logic pull_active_valid;
    logic pull_active_updated;
    logic pull_active_pull_first;
    v_id_t pull_active_id;

    // fifo head
    v_id_t top_id;
    depth_t top_depth;
    logic top_push_flag;
    logic top_pull_first;
    logic fifo_empty;

    // bank ports
    logic ram_wr_en;
    bank_addr_t ram_wr_addr;
    depth_t ram_wr_data;
    depth_t rd_data;
    logic rd_data_valid;

    vtx_req_issue u_issue (
        .clk                    (clk),
        .rst                    (rst),
        .rd_valid_src           (rd_valid_src),
        .rd_addr_src            (rd_addr_src),
        .wr_valid_dst           (wr_valid_dst),
        .wr_push_flag_dst       (wr_push_flag_dst),
        .wr_pull_first_flag_dst (wr_pull_first_flag_dst),
        .wr_addr_dst            (wr_addr_dst),
        .wr_v_value_dst         (wr_v_value_dst),
        .front_iteration_id     (front_iteration_id),
        .rd_req                 (rd_req),
        .rd_bank_addr           (rd_bank_addr),
        .rd_null                (rd_null),
        .fifo_push              (fifo_push),
        .fifo_id                (fifo_id),
        .fifo_depth             (fifo_depth),
        .fifo_push_flag         (fifo_push_flag),
        .fifo_pull_first        (fifo_pull_first),
        .pull_wr                (pull_wr),
        .pull_wr_addr           (pull_wr_addr),
        .pull_wr_data           (pull_wr_data),
        .pull_active_valid      (pull_active_valid),
        .pull_active_updated    (pull_active_updated),
        .pull_active_pull_first (pull_active_pull_first),
        .pull_active_id         (pull_active_id)
    );

    // popped as each bank word returns
    vtx_push_fifo u_fifo (
        .clk             (clk),
        .rst             (rst),
        .push            (fifo_push),
        .push_id         (fifo_id),
        .push_depth      (fifo_depth),
        .push_flag       (fifo_push_flag),
        .push_pull_first (fifo_pull_first),
        .pop             (rd_data_valid),
        .top_id          (top_id),
        .top_depth       (top_depth),
        .top_push_flag   (top_push_flag),
        .top_pull_first  (top_pull_first),
        .empty           (fifo_empty)
    );

    vtx_update_resolve u_resolve (
        .clk                              (clk),
        .rst                              (rst),
        .rd_data                          (rd_data),
        .rd_data_valid                    (rd_data_valid),
        .top_id                           (top_id),
        .top_depth                        (top_depth),
        .top_push_flag                    (top_push_flag),
        .top_pull_first                   (top_pull_first),
        .fifo_empty                       (fifo_empty),
        .pull_wr                          (pull_wr),
        .pull_wr_addr                     (pull_wr_addr),
        .pull_wr_data                     (pull_wr_data),
        .pull_active_valid                (pull_active_valid),
        .pull_active_updated              (pull_active_updated),
        .pull_active_pull_first           (pull_active_pull_first),
        .pull_active_id                   (pull_active_id),
        .front_iteration_end              (front_iteration_end),
        .front_iteration_end_valid        (front_iteration_end_valid),
        .ram_wr_en                        (ram_wr_en),
        .ram_wr_addr                      (ram_wr_addr),
        .ram_wr_data                      (ram_wr_data),
        .src_recv_update_v_valid          (src_recv_update_v_valid),
        .src_recv_update_v_value          (src_recv_update_v_value),
        .backend_active_v_valid           (backend_active_v_valid),
        .backend_active_v_id              (backend_active_v_id),
        .backend_active_v_updated         (backend_active_v_updated),
        .backend_active_v_pull_first_flag (backend_active_v_pull_first_flag),
        .iteration_end                    (iteration_end),
        .iteration_end_valid              (iteration_end_valid)
    );

    vtx_depth_ram u_ram (
        .clk           (clk),
        .rst           (rst),
        .wr_en         (ram_wr_en),
        .wr_addr       (ram_wr_addr),
        .wr_data       (ram_wr_data),
        .rd_req        (rd_req),
        .rd_addr       (rd_bank_addr),
        .rd_null       (rd_null),
        .root_id       (front_root_id),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

endmodule

`default_nettype wire

// ==== logic/vtx_depth_ram.sv ====
`default_nettype none

`include "vtx_macros.svh"

module vtx_depth_ram
    import vtx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  bank_addr_t wr_addr,
    input  depth_t     wr_data,
    input  logic       rd_req,
    input  bank_addr_t rd_addr,
    input  logic       rd_null,
    input  v_id_t      root_id,
    output depth_t     rd_data,
    output logic       rd_data_valid
);

    // one depth per vertex owned by this core
    depth_t mem [0:(1 << `BANK_AWIDTH)-1];

    // armed during reset, fires once on the first cycle out of it
    logic seed_root;
    bank_addr_t root_addr;

    // first read stage
    depth_t rd_data_q;
    logic rd_valid_q;
    logic rd_null_q;

    integer i;

    // all vertices start unvisited
    initial begin
        for (i = 0; i < (1 << `BANK_AWIDTH); i = i + 1) begin
            mem[i] = `INVALID_BFS_VALUE;
        end
    end

    // interleave bits dropped
    assign root_addr = root_id[`V_ID_WIDTH-1:`CORE_NUM_WIDTH];

    always_ff @(posedge clk) begin
        seed_root <= rst;
    end

    always_ff @(posedge clk) begin
        // root gets depth 0, it owns the write port in that cycle
        if (seed_root && !rst) begin
            mem[root_addr] <= '0;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // read-first, a colliding write is seen on the next read
        rd_data_q <= mem[rd_addr];
    end

    // second stage, null read replaced by the pull marker
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid_q <= 1'b0;
            rd_data_valid <= 1'b0;
        end else begin
            rd_valid_q <= rd_req;
            rd_data_valid <= rd_valid_q;
        end
        rd_null_q <= rd_null;
        rd_data <= rd_null_q ? `INVALID_PULL_VALUE : rd_data_q;
    end

    // issuer and resolver are idle on the seed cycle
    a_no_write_on_seed: assert property (@(posedge clk) disable iff (rst)
        seed_root |-> !wr_en)
        else $error("depth bank write collides with root seed");

endmodule

`default_nettype wire

// ==== logic/vtx_macros.svh ====
`ifndef VTX_MACROS_SVH
`define VTX_MACROS_SVH

// full vertex id as seen by the front end
`define V_ID_WIDTH 12

// low id bits select the core, dropped to form the bank address
`define CORE_NUM_WIDTH 2

// id width minus the interleave bits
`define BANK_AWIDTH 10

// bfs depth and iteration counter
`define DEPTH_WIDTH 8
`define ITER_WIDTH 8

// depth of a vertex not yet reached
`define INVALID_BFS_VALUE {`DEPTH_WIDTH{1'b1}}

// returned for a read of the null id (all ones)
`define INVALID_PULL_VALUE {`DEPTH_WIDTH{1'b1}}

// pending read/push context, fixed pop latency keeps it at 3 or fewer
`define PUSH_FIFO_DEPTH 8

`endif

// ==== logic/vtx_pkg.sv ====
`default_nettype none

`include "vtx_macros.svh"

package vtx_pkg;

    // vertex id from the front end, core select in the low bits
    typedef logic [`V_ID_WIDTH-1:0] v_id_t;

    // bfs depth, all ones means unvisited
    typedef logic [`DEPTH_WIDTH-1:0] depth_t;

    // word address inside this core's depth bank
    typedef logic [`BANK_AWIDTH-1:0] bank_addr_t;

    // current bfs iteration
    typedef logic [`ITER_WIDTH-1:0] iter_id_t;

endpackage

`default_nettype wire

// ==== logic/vtx_push_fifo.sv ====
`default_nettype none

`include "vtx_macros.svh"

module vtx_push_fifo
    import vtx_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  v_id_t  push_id,
    input  depth_t push_depth,
    input  logic   push_flag,
    input  logic   push_pull_first,
    input  logic   pop,
    output v_id_t  top_id,
    output depth_t top_depth,
    output logic   top_push_flag,
    output logic   top_pull_first,
    output logic   empty
);

    // context storage, one slot per outstanding bank read
    v_id_t id_mem [0:`PUSH_FIFO_DEPTH-1];
    depth_t depth_mem [0:`PUSH_FIFO_DEPTH-1];
    logic flag_mem [0:`PUSH_FIFO_DEPTH-1];
    logic pull_first_mem [0:`PUSH_FIFO_DEPTH-1];

    logic [$clog2(`PUSH_FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(`PUSH_FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(`PUSH_FIFO_DEPTH):0] count;

    // fall-through head, valid whenever not empty
    assign top_id = id_mem[rd_ptr];
    assign top_depth = depth_mem[rd_ptr];
    assign top_push_flag = flag_mem[rd_ptr];
    assign top_pull_first = pull_first_mem[rd_ptr];
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (push) begin
            id_mem[wr_ptr] <= push_id;
            depth_mem[wr_ptr] <= push_depth;
            flag_mem[wr_ptr] <= push_flag;
            pull_first_mem[wr_ptr] <= push_pull_first;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // bank latency bounds occupancy, so full means a broken pipeline
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(push && !pop && count == `PUSH_FIFO_DEPTH))
        else $error("push fifo overflow");

    // every returning bank word must have a context waiting
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        !(pop && empty))
        else $error("push fifo popped while empty");

endmodule

`default_nettype wire

// ==== logic/vtx_req_issue.sv ====
`default_nettype none

`include "vtx_macros.svh"

module vtx_req_issue
    import vtx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rd_valid_src,
    input  v_id_t      rd_addr_src,
    input  logic       wr_valid_dst,
    input  logic       wr_push_flag_dst,
    input  logic       wr_pull_first_flag_dst,
    input  v_id_t      wr_addr_dst,
    input  depth_t     wr_v_value_dst,
    input  iter_id_t   front_iteration_id,
    output logic       rd_req,
    output bank_addr_t rd_bank_addr,
    output logic       rd_null,
    output logic       fifo_push,
    output v_id_t      fifo_id,
    output depth_t     fifo_depth,
    output logic       fifo_push_flag,
    output logic       fifo_pull_first,
    output logic       pull_wr,
    output bank_addr_t pull_wr_addr,
    output depth_t     pull_wr_data,
    output logic       pull_active_valid,
    output logic       pull_active_updated,
    output logic       pull_active_pull_first,
    output v_id_t      pull_active_id
);

    logic take_push;
    logic take_pull;
    logic pull_ok;

    // source read wins, a push in the same cycle is lost
    assign take_push = !rd_valid_src && wr_valid_dst && wr_push_flag_dst;

    // pulls skip the fifo and are never masked by a read
    assign take_pull = wr_valid_dst && !wr_push_flag_dst;

    // offered depth visited and not past the current iteration
    assign pull_ok = (wr_v_value_dst != `INVALID_BFS_VALUE) &&
                     (wr_v_value_dst <= front_iteration_id);

    // context enters the fifo on the sampling edge
    // a read carries an all zero context
    assign fifo_push = rd_valid_src || take_push;
    assign fifo_id = take_push ? wr_addr_dst : '0;
    assign fifo_depth = take_push ? wr_v_value_dst : '0;
    assign fifo_push_flag = take_push;
    assign fifo_pull_first = take_push && wr_pull_first_flag_dst;

    // bank lookup for reads and pushes
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_req <= 1'b0;
        end else begin
            rd_req <= fifo_push;
        end
        // null id bypasses the lookup result
        rd_null <= rd_valid_src && (rd_addr_src == '1);
        if (rd_valid_src) begin
            rd_bank_addr <= rd_addr_src[`V_ID_WIDTH-1:`CORE_NUM_WIDTH];
        end else begin
            rd_bank_addr <= wr_addr_dst[`V_ID_WIDTH-1:`CORE_NUM_WIDTH];
        end
    end

    // pull write goes straight to the bank, report goes via the resolver
    always_ff @(posedge clk) begin
        if (rst) begin
            pull_wr <= 1'b0;
            pull_active_valid <= 1'b0;
        end else begin
            pull_wr <= take_pull && pull_ok;
            pull_active_valid <= take_pull;
        end
        pull_wr_addr <= wr_addr_dst[`V_ID_WIDTH-1:`CORE_NUM_WIDTH];
        // reached one level past the offered depth
        pull_wr_data <= wr_v_value_dst + 1'b1;
        pull_active_id <= wr_addr_dst;
        pull_active_updated <= pull_ok;
        pull_active_pull_first <= wr_pull_first_flag_dst;
    end

endmodule

`default_nettype wire

// ==== logic/vtx_update_resolve.sv ====
`default_nettype none

`include "vtx_macros.svh"

module vtx_update_resolve
    import vtx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  depth_t     rd_data,
    input  logic       rd_data_valid,
    input  v_id_t      top_id,
    input  depth_t     top_depth,
    input  logic       top_push_flag,
    input  logic       top_pull_first,
    input  logic       fifo_empty,
    input  logic       pull_wr,
    input  bank_addr_t pull_wr_addr,
    input  depth_t     pull_wr_data,
    input  logic       pull_active_valid,
    input  logic       pull_active_updated,
    input  logic       pull_active_pull_first,
    input  v_id_t      pull_active_id,
    input  logic       front_iteration_end,
    input  logic       front_iteration_end_valid,
    output logic       ram_wr_en,
    output bank_addr_t ram_wr_addr,
    output depth_t     ram_wr_data,
    output logic       src_recv_update_v_valid,
    output depth_t     src_recv_update_v_value,
    output logic       backend_active_v_valid,
    output v_id_t      backend_active_v_id,
    output logic       backend_active_v_updated,
    output logic       backend_active_v_pull_first_flag,
    output logic       iteration_end,
    output logic       iteration_end_valid
);

    // registered push result
    logic push_wr_en;
    bank_addr_t push_wr_addr;
    depth_t push_wr_data;
    logic push_rpt_valid;
    logic push_rpt_updated;
    logic push_rpt_pull_first;
    v_id_t push_rpt_id;

    logic push_win;

    // offered depth beats an unvisited or deeper stored depth
    assign push_win = (rd_data == `INVALID_BFS_VALUE) || (rd_data > top_depth);

    always_ff @(posedge clk) begin
        if (rst) begin
            push_wr_en <= 1'b0;
            push_rpt_valid <= 1'b0;
            src_recv_update_v_valid <= 1'b0;
        end else begin
            push_wr_en <= rd_data_valid && top_push_flag && push_win;
            push_rpt_valid <= rd_data_valid && top_push_flag;
            // no push flag means a source read
            src_recv_update_v_valid <= rd_data_valid && !top_push_flag;
        end
        push_wr_addr <= top_id[`V_ID_WIDTH-1:`CORE_NUM_WIDTH];
        push_wr_data <= top_depth;
        push_rpt_id <= top_id;
        push_rpt_updated <= push_win;
        push_rpt_pull_first <= top_pull_first;
        src_recv_update_v_value <= rd_data;
    end

    // pull cycle owns the write port and the report
    // a push result landing in that cycle is dropped
    assign ram_wr_en = pull_active_valid ? pull_wr : push_wr_en;
    assign ram_wr_addr = pull_active_valid ? pull_wr_addr : push_wr_addr;
    assign ram_wr_data = pull_active_valid ? pull_wr_data : push_wr_data;

    assign backend_active_v_valid = pull_active_valid || push_rpt_valid;
    assign backend_active_v_id = pull_active_valid ? pull_active_id : push_rpt_id;
    assign backend_active_v_updated =
        pull_active_valid ? pull_active_updated : push_rpt_updated;
    assign backend_active_v_pull_first_flag =
        pull_active_valid ? pull_active_pull_first : push_rpt_pull_first;

    // iteration over only once no read or push is in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            iteration_end <= 1'b0;
            iteration_end_valid <= 1'b0;
        end else begin
            iteration_end <= front_iteration_end && front_iteration_end_valid && fifo_empty;
            iteration_end_valid <= front_iteration_end && front_iteration_end_valid &&
                                   fifo_empty;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
+incdir+dv
logic/vtx_pkg.sv
logic/vtx_depth_ram.sv
logic/vtx_req_issue.sv
logic/vtx_push_fifo.sv
logic/vtx_update_resolve.sv
logic/vtx_bram_core.sv
dv/vtx_bram_core_tb.sv
